//--- flist.f
source/alu_bist_pkg.sv
source/alu.sv
source/bist_sequencer.sv
source/result_checker.sv
source/wb_bist_regs.sv
source/alu_bist_top.sv
sim/tb_alu_bist.sv

//--- run_sim.sh
#!/bin/sh
# build and run the alu bist testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_alu_bist -o tb_alu_bist

out=$(./obj_dir/tb_alu_bist)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

//--- sim/tb_alu_bist.sv
/*
 * testbench for the alu bist
 * runs the self test over wishbone with and without fault injection
 * and checks the read back status against a reference model
 */
`timescale 1ns/100ps

module tb_alu_bist import alu_bist_pkg::*; ();

    localparam int TIMEOUT = 50;                    // cycles or polls per wait loop
    localparam int N_STEPS = 8;

    logic                clk;
    logic                rst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [WB_DAT_W-1:0] wb_dat_w;
    logic [WB_DAT_W-1:0] wb_dat_r;
    logic                wb_ack;

    logic [OP_W-1:0]     scr_op   [1:N_STEPS];      // step list copy
    logic [ALU_W-1:0]    scr_arg0 [1:N_STEPS];
    logic [ALU_W-1:0]    scr_arg1 [1:N_STEPS];
    logic                scr_cmp  [1:N_STEPS];
    logic [ALU_W-1:0]    scr_xpct [1:N_STEPS];      // checks result of step before

    int   seed;
    int   checks;
    int   errors;
    logic exp_passed;
    int   exp_fails;
    int   exp_first;

    alu_bist_top #(
        .P_FAIL_CNT_W (8)
    ) i_alu_bist_top (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;                           // 4 ns period

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic set_step(input int s, input logic [OP_W-1:0] op, input logic [ALU_W-1:0] a,
                            input logic [ALU_W-1:0] b, input logic cmp,
                            input logic [ALU_W-1:0] x);
        scr_op[s]   = op;
        scr_arg0[s] = a;
        scr_arg1[s] = b;
        scr_cmp[s]  = cmp;
        scr_xpct[s] = x;
    endtask

    function automatic logic [ALU_W-1:0] alu_ref(input logic [OP_W-1:0] op,
                                                 input logic [ALU_W-1:0] a,
                                                 input logic [ALU_W-1:0] b, input logic inj);
        logic [ALU_W-1:0] r;
        case (op)
            OP_NOP:  r = a;
            OP_ADD:  r = a + b;                     // 8 bit wrap
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_ROL:  r = {a[ALU_W-2:0], a[ALU_W-1]};
            default: r = '0;
        endcase
        r[0] = r[0] ^ inj;                          // fault inject on lsb
        return r;
    endfunction

    // expected pass, count and first failing step for one run
    task automatic predict(input logic inj);
        exp_fails = 0;
        exp_first = 0;
        for (int s = 2; s <= N_STEPS; s++) begin
            if (scr_cmp[s] &&
                alu_ref(scr_op[s-1], scr_arg0[s-1], scr_arg1[s-1], inj) != scr_xpct[s]) begin
                if (exp_fails == 0) begin
                    exp_first = s;
                end
                exp_fails++;
            end
        end
        exp_passed = (exp_fails == 0);
    endtask

    // starts and ends just after a falling edge
    task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                             input logic [WB_DAT_W-1:0] wdat,
                             output logic [WB_DAT_W-1:0] rdat);
        int cnt;
        cnt    = 0;
        rdat   = '0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        wb_dat_w = wdat;
        do begin
            @(negedge clk);
            cnt++;
        end while (!wb_ack && cnt < TIMEOUT);
        if (!wb_ack) begin
            errors++;
            $display("ERROR t=%0t no ack for access to address %0d within %0d cycles",
                     $time, adr, TIMEOUT);
        end else begin
            rdat = wb_dat_r;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        check_val("o_wb_ack single pulse", 32'(wb_ack), 32'd0);
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
        logic [WB_DAT_W-1:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    task automatic poll_done();
        logic [WB_DAT_W-1:0] st;
        int n;
        n = 0;
        do begin
            wb_read(REG_STATUS, st);
            n++;
        end while (!st[STAT_DONE] && n < TIMEOUT);
        if (!st[STAT_DONE]) begin
            errors++;
            $display("ERROR t=%0t self test never reported done after %0d status reads",
                     $time, n);
        end
    endtask

    task automatic check_results(input logic inj);
        logic [WB_DAT_W-1:0] rd;
        predict(inj);
        wb_read(REG_STATUS, rd);
        check_val("status.running", 32'(rd[STAT_RUNNING]), 32'd0);
        check_val("status.done", 32'(rd[STAT_DONE]), 32'd1);
        check_val("status.passed", 32'(rd[STAT_PASSED]), 32'(exp_passed));
        wb_read(REG_FAILS, rd);
        check_val("fails", rd, exp_fails);
        wb_read(REG_FIRST, rd);
        check_val("first", rd, exp_first);
    endtask

    // random write to a read only register must leave the predicted value
    task automatic write_ro_check(input logic [WB_ADR_W-1:0] adr,
                                  input logic [WB_DAT_W-1:0] exp, input string name);
        logic [WB_DAT_W-1:0] after;
        wb_write(adr, $random(seed));
        wb_read(adr, after);
        check_val(name, after, exp);
    endtask

    task automatic start_run(input logic [WB_DAT_W-1:0] ctrl);
        logic [WB_DAT_W-1:0] rd;
        wb_write(REG_CTRL, ctrl);
        wb_read(REG_STATUS, rd);                    // sequencer already stepping
        check_val("status.running after start", 32'(rd[STAT_RUNNING]), 32'd1);
    endtask

    initial begin
        logic [WB_DAT_W-1:0] rd;
        logic [WB_DAT_W-1:0] exp_status;
        seed     = 32'h5218_f391;
        checks   = 0;
        errors   = 0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        set_step(1, OP_NOP, 8'h00, 8'h00, 1'b0, 8'h00);
        set_step(2, OP_ADD, 8'd5,  8'd8,  1'b0, 8'h00);
        set_step(3, OP_SUB, 8'd8,  8'd13, 1'b1, 8'd13);
        set_step(4, OP_AND, 8'hCC, 8'hAA, 1'b1, 8'hFB);
        set_step(5, OP_OR,  8'hAA, 8'hCC, 1'b1, 8'h88);
        set_step(6, OP_XOR, 8'hCA, 8'hAC, 1'b1, 8'hEE);
        set_step(7, OP_ROL, 8'h9A, 8'h00, 1'b1, 8'h66);
        set_step(8, OP_NOP, 8'h00, 8'h00, 1'b1, 8'h35);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        wb_read(REG_STATUS, rd);                    // idle, not done, passed
        check_val("status after reset", rd, 32'h4);
        wb_read(REG_FAILS, rd);
        check_val("fails after reset", rd, 32'd0);
        wb_read(REG_FIRST, rd);
        check_val("first after reset", rd, 32'd0);

        start_run(32'h1);                           // clean run
        poll_done();
        check_results(1'b0);

        start_run(32'h3);                           // inject on
        wb_write(REG_CTRL, 32'h3);                  // restart mid run is ignored
        poll_done();
        check_results(1'b1);

        exp_status              = '0;               // idle and done after the faulty run
        exp_status[STAT_DONE]   = 1'b1;
        exp_status[STAT_PASSED] = exp_passed;
        write_ro_check(REG_STATUS, exp_status, "status after write");
        write_ro_check(REG_FAILS, exp_fails, "fails after write");
        write_ro_check(REG_FIRST, exp_first, "first after write");

        wb_read(REG_CTRL, rd);
        check_val("ctrl.inject set", rd, 32'h2);
        wb_write(REG_CTRL, 32'h0);                  // clears inject without a start
        wb_read(REG_CTRL, rd);
        check_val("ctrl.inject cleared", rd, 32'h0);
        start_run(32'h1);
        poll_done();
        check_results(1'b0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- source/alu_bist_top.sv
/*
 * alu bist top level
 * wishbone registers, script sequencer, alu and result checker
 */
`timescale 1ns/100ps

module alu_bist_top import alu_bist_pkg::*; #(
    parameter int P_FAIL_CNT_W = 8                  // fail counter width, 4 to 32
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_wb_cyc,
    input  logic                i_wb_stb,
    input  logic                i_wb_we,
    input  logic [WB_ADR_W-1:0] i_wb_adr,
    input  logic [WB_DAT_W-1:0] i_wb_dat,
    output logic [WB_DAT_W-1:0] o_wb_dat,
    output logic                o_wb_ack
);

    logic                    start;                 // regs -> sequencer, checker
    logic                    inject;
    logic [OP_W-1:0]         op;
    logic [ALU_W-1:0]        arg0;
    logic [ALU_W-1:0]        arg1;
    logic                    cmp;
    logic [ALU_W-1:0]        xpct;
    logic [STEP_W-1:0]       step;
    logic                    running;
    logic [ALU_W-1:0]        data;                  // alu result
    logic                    done;
    logic                    passed;
    logic [P_FAIL_CNT_W-1:0] fails;
    logic [STEP_W-1:0]       first;

    wb_bist_regs #(
        .P_FAIL_CNT_W (P_FAIL_CNT_W)
    ) u_regs (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_stb  (i_wb_stb),
        .i_wb_we   (i_wb_we),
        .i_wb_adr  (i_wb_adr),
        .i_wb_dat  (i_wb_dat),
        .i_running (running),
        .i_done    (done),
        .i_passed  (passed),
        .i_fails   (fails),
        .i_first   (first),
        .o_wb_dat  (o_wb_dat),
        .o_wb_ack  (o_wb_ack),
        .o_start   (start),
        .o_inject  (inject)
    );

    bist_sequencer u_seq (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (start),
        .o_op      (op),
        .o_arg0    (arg0),
        .o_arg1    (arg1),
        .o_cmp     (cmp),
        .o_xpct    (xpct),
        .o_step    (step),
        .o_running (running)
    );

    alu u_alu (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_op     (op),
        .i_arg0   (arg0),
        .i_arg1   (arg1),
        .i_inject (inject),
        .o_data   (data)
    );

    result_checker #(
        .P_FAIL_CNT_W (P_FAIL_CNT_W)
    ) u_chk (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (start),
        .i_running (running),
        .i_cmp     (cmp),
        .i_xpct    (xpct),
        .i_step    (step),
        .i_data    (data),
        .o_done    (done),
        .o_passed  (passed),
        .o_fails   (fails),
        .o_first   (first)
    );

endmodule

//--- source/wb_bist_regs.sv
/*
 * wishbone classic register block for the bist
 * control register with start and inject, read back of status,
 * fail count and first failing step; single cycle ack, no wait states
 */
`timescale 1ns/100ps

module wb_bist_regs import alu_bist_pkg::*; #(
    parameter int P_FAIL_CNT_W = 8
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_wb_cyc,
    input  logic                    i_wb_stb,
    input  logic                    i_wb_we,
    input  logic [WB_ADR_W-1:0]     i_wb_adr,
    input  logic [WB_DAT_W-1:0]     i_wb_dat,
    input  logic                    i_running,
    input  logic                    i_done,
    input  logic                    i_passed,
    input  logic [P_FAIL_CNT_W-1:0] i_fails,
    input  logic [STEP_W-1:0]       i_first,
    output logic [WB_DAT_W-1:0]     o_wb_dat,       // valid with ack
    output logic                    o_wb_ack,
    output logic                    o_start,        // one cycle pulse
    output logic                    o_inject
);

    logic                access;                    // new bus cycle sampled
    logic                wr_ctrl;
    logic [WB_DAT_W-1:0] rd_data;

    // ack blocks a second sample of the same held request
    assign access  = i_wb_cyc & i_wb_stb & ~o_wb_ack;
    assign wr_ctrl = access & i_wb_we & (i_wb_adr == REG_CTRL);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
            o_start  <= 1'b0;
            o_inject <= 1'b0;
        end else begin
            o_wb_ack <= access;                     // every access acked once
            o_start  <= wr_ctrl & i_wb_dat[CTRL_START];
            if (wr_ctrl) begin
                o_inject <= i_wb_dat[CTRL_INJECT];
            end
        end
    end

    // read mux
    always_comb begin
        rd_data = '0;
        case (i_wb_adr)
            REG_CTRL: begin
                rd_data[CTRL_INJECT] = o_inject;    // start reads back 0
            end
            REG_STATUS: begin
                rd_data[STAT_RUNNING] = i_running;
                rd_data[STAT_DONE]    = i_done;
                rd_data[STAT_PASSED]  = i_passed;
            end
            REG_FAILS: begin
                rd_data[P_FAIL_CNT_W-1:0] = i_fails;
            end
            default: begin
                rd_data[STEP_W-1:0] = i_first;      // REG_FIRST
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            o_wb_dat <= rd_data;                    // lands with ack
        end
    end

endmodule

//--- source/result_checker.sv
/*
 * bist result checker
 * lines up compare flag, expected value and step with the alu result,
 * counts mismatches, records the first failing step and flags done
 */
`timescale 1ns/100ps

module result_checker import alu_bist_pkg::*; #(
    parameter int P_FAIL_CNT_W = 8
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,        // start request from host
    input  logic                    i_running,      // sequencer busy
    input  logic                    i_cmp,
    input  logic [ALU_W-1:0]        i_xpct,
    input  logic [STEP_W-1:0]       i_step,
    input  logic [ALU_W-1:0]        i_data,         // registered alu result
    output logic                    o_done,
    output logic                    o_passed,
    output logic [P_FAIL_CNT_W-1:0] o_fails,        // saturating count
    output logic [STEP_W-1:0]       o_first         // 0 when no failure
);

    logic              r_cmp;                       // aligned compare flag
    logic [ALU_W-1:0]  r_xpct;
    logic [STEP_W-1:0] r_step;
    logic [ALU_W-1:0]  r_data;
    logic              r_running;                   // running one cycle ago
    logic              clear;                       // accepted start
    logic              mismatch;

    assign clear    = i_start & ~i_running;         // same rule as sequencer
    assign mismatch = r_cmp && (r_data != r_xpct);

    // pipeline payload
    always_ff @(posedge i_clk) begin
        r_xpct <= i_xpct;
        r_step <= i_step;
        r_data <= i_data;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_cmp     <= 1'b0;
            r_running <= 1'b0;
            o_done    <= 1'b0;
            o_passed  <= 1'b1;                      // nothing failed yet
            o_fails   <= '0;
            o_first   <= '0;
        end else begin
            r_cmp     <= i_cmp;
            r_running <= i_running;
            if (clear) begin
                o_done   <= 1'b0;
                o_passed <= 1'b1;
                o_fails  <= '0;
                o_first  <= '0;
            end else begin
                if (mismatch) begin
                    o_passed <= 1'b0;
                    if (o_passed) begin
                        o_first <= r_step;          // first failure only
                    end
                    if (o_fails != '1) begin
                        o_fails <= o_fails + 1'b1;
                    end
                end
                if (r_running && !i_running) begin
                    o_done <= 1'b1;                 // pipeline tail drained
                end
            end
        end
    end

endmodule

//--- source/bist_sequencer.sv
/*
 * bist script sequencer
 * walks a fixed script of alu operations one step per cycle and
 * presents the operands and the expected values for the checker
 */
`timescale 1ns/100ps

module bist_sequencer import alu_bist_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_start,              // one cycle start pulse
    output logic [OP_W-1:0]   o_op,
    output logic [ALU_W-1:0]  o_arg0,
    output logic [ALU_W-1:0]  o_arg1,
    output logic              o_cmp,                // compare enable for this step
    output logic [ALU_W-1:0]  o_xpct,               // expected result of previous step
    output logic [STEP_W-1:0] o_step,               // current step index
    output logic              o_running
);

    logic [STEP_W-1:0]   step;                      // state register
    logic [SCRIPT_W-1:0] script;                    // word for current step
    logic [STEP_W-1:0]   next_step;

    // script table
    // each expectation checks the result of the step before it
    always_comb begin
        case (step)
            4'h1:    script = {OP_NOP, 8'h00, 8'h00, 1'b0, 8'h00, 4'h2};
            4'h2:    script = {OP_ADD, 8'd5,  8'd8,  1'b0, 8'h00, 4'h3};
            4'h3:    script = {OP_SUB, 8'd8,  8'd13, 1'b1, 8'd13, 4'h4}; // 5 + 8
            4'h4:    script = {OP_AND, 8'hCC, 8'hAA, 1'b1, 8'hFB, 4'h5}; // 8 - 13 = -5
            4'h5:    script = {OP_OR,  8'hAA, 8'hCC, 1'b1, 8'h88, 4'h6}; // and
            4'h6:    script = {OP_XOR, 8'hCA, 8'hAC, 1'b1, 8'hEE, 4'h7}; // or
            4'h7:    script = {OP_ROL, 8'h9A, 8'h00, 1'b1, 8'h66, 4'h8}; // xor
            4'h8:    script = {OP_NOP, 8'h00, 8'h00, 1'b1, 8'h35, STEP_DONE}; // rol
            STEP_DONE:
                     script = {OP_NOP, 8'h00, 8'h00, 1'b0, 8'h00, STEP_STOP};
            default: script = {OP_NOP, 8'h00, 8'h00, 1'b0, 8'h00, STEP_STOP}; // idle
        endcase
    end

    // field split
    assign o_op      = script[FLD_OP_HI:FLD_OP_LO];
    assign o_arg0    = script[FLD_ARG0_HI:FLD_ARG0_LO];
    assign o_arg1    = script[FLD_ARG1_HI:FLD_ARG1_LO];
    assign o_cmp     = script[FLD_CMP];
    assign o_xpct    = script[FLD_XPCT_HI:FLD_XPCT_LO];
    assign next_step = script[FLD_NEXT_HI:FLD_NEXT_LO];

    assign o_step    = step;
    assign o_running = (step != STEP_STOP);         // 9 cycles per run

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            step <= STEP_STOP;
        end else if (step == STEP_STOP) begin
            if (i_start) begin
                step <= STEP_FIRST;                 // start only from idle
            end
        end else begin
            step <= next_step;                      // start ignored mid run
        end
    end

endmodule

//--- source/alu.sv
/*
 * registered 8 bit alu
 * decodes the opcode and registers the result one cycle later,
 * optionally flipping bit 0 so the checker can be exercised
 */
`timescale 1ns/100ps

module alu import alu_bist_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic [OP_W-1:0]  i_op,                  // operation select
    input  logic [ALU_W-1:0] i_arg0,
    input  logic [ALU_W-1:0] i_arg1,
    input  logic             i_inject,              // corrupt bit 0 of result
    output logic [ALU_W-1:0] o_data                 // registered result
);

    logic [ALU_W-1:0] result;                       // combinational result
    logic [ALU_W-1:0] flip;                         // fault mask

    always_comb begin
        case (i_op)
            OP_NOP:  result = i_arg0;               // pass through
            OP_ADD:  result = i_arg0 + i_arg1;      // wraps, no carry out
            OP_SUB:  result = i_arg0 - i_arg1;
            OP_AND:  result = i_arg0 & i_arg1;
            OP_OR:   result = i_arg0 | i_arg1;
            OP_XOR:  result = i_arg0 ^ i_arg1;
            OP_ROL:  result = {i_arg0[ALU_W-2:0], i_arg0[ALU_W-1]};
            default: result = '0;                   // unknown op
        endcase
    end

    // only the lsb is ever corrupted
    always_comb begin
        flip    = '0;
        flip[0] = i_inject;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data <= '0;
        end else begin
            o_data <= result ^ flip;                // one cycle latency
        end
    end

endmodule

//--- source/alu_bist_pkg.sv
/*
 * alu bist shared definitions
 * opcodes, script word layout, step states, register map and widths
 */
package alu_bist_pkg;

    parameter int ALU_W    = 8;                     // script values are 8 bit
    parameter int OP_W     = 4;
    parameter int STEP_W   = 4;
    parameter int SCRIPT_W = 33;                    // op, arg0, arg1, cmp, xpct, next
    parameter int WB_DAT_W = 32;
    parameter int WB_ADR_W = 2;                     // word address

    parameter logic [OP_W-1:0] OP_NOP = 4'h0;       // arg0 -> data
    parameter logic [OP_W-1:0] OP_ADD = 4'h1;       // arg0 + arg1
    parameter logic [OP_W-1:0] OP_SUB = 4'h2;       // arg0 - arg1
    parameter logic [OP_W-1:0] OP_AND = 4'h4;
    parameter logic [OP_W-1:0] OP_OR  = 4'h5;
    parameter logic [OP_W-1:0] OP_XOR = 4'h6;
    parameter logic [OP_W-1:0] OP_ROL = 4'h8;       // arg0 rotated left by one

    parameter logic [STEP_W-1:0] STEP_STOP  = 4'h0; // idle
    parameter logic [STEP_W-1:0] STEP_FIRST = 4'h1;
    parameter logic [STEP_W-1:0] STEP_DONE  = 4'hF; // last state, then stop

    // script word bit positions, high to low
    parameter int FLD_OP_HI   = 32;
    parameter int FLD_OP_LO   = 29;
    parameter int FLD_ARG0_HI = 28;
    parameter int FLD_ARG0_LO = 21;
    parameter int FLD_ARG1_HI = 20;
    parameter int FLD_ARG1_LO = 13;
    parameter int FLD_CMP     = 12;
    parameter int FLD_XPCT_HI = 11;
    parameter int FLD_XPCT_LO = 4;
    parameter int FLD_NEXT_HI = 3;
    parameter int FLD_NEXT_LO = 0;

    parameter logic [WB_ADR_W-1:0] REG_CTRL   = 2'd0;
    parameter logic [WB_ADR_W-1:0] REG_STATUS = 2'd1;
    parameter logic [WB_ADR_W-1:0] REG_FAILS  = 2'd2;
    parameter logic [WB_ADR_W-1:0] REG_FIRST  = 2'd3;

    parameter int CTRL_START     = 0;               // write 1, self clearing
    parameter int CTRL_INJECT    = 1;               // sticky
    parameter int STAT_RUNNING   = 0;
    parameter int STAT_DONE      = 1;
    parameter int STAT_PASSED    = 2;

endpackage
